// File: nocArbiter.f
+incdir+src
+incdir+test
src/nocArbiterPkg.sv
src/holdTimer.sv
src/portArbiter.sv
src/switchTraversal.sv
src/arbiterTop.sv
test/arbiterTb.sv

// File: runSim.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench reports a pass
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f nocArbiter.f --top-module arbiterTb \
  -o arbiterSim &&
  ./obj_dir/arbiterSim | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
  echo "Simulation run passed" ||
  { echo "Simulation run failed"; exit 1; }

// File: src/arbiterTop.sv
`default_nettype none

`include "nocArbiter_config.svh"

// One output port of the router with arbitration and switch traversal
module arbiterTop
  import nocArbiterPkg::*;
(
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic [`NOC_PORTS-1:0]       req,
  input  wire flitId_t [`NOC_PORTS-1:0]    flitId,
  input  wire pktLength_t [`NOC_PORTS-1:0] length,
  input  wire flitData_t [`NOC_PORTS-1:0]  flitData,
  output grantState_t                      grant,
  output flitData_t                        outData,
  output logic                             outValid,
  output pktLength_t                       grantFlits
);

  grantState_t arbGrant;

  // Grant decision and hold timers
  portArbiter Arbiter (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .flitId (flitId),
    .length (length),
    .grant  (arbGrant)
  );

  // Registered output link one cycle behind the grant
  switchTraversal Traversal (
    .clk        (clk),
    .rst        (rst),
    .grant      (arbGrant),
    .req        (req),
    .flitData   (flitData),
    .outData    (outData),
    .outValid   (outValid),
    .grantFlits (grantFlits)
  );

  assign grant = arbGrant;

endmodule

`default_nettype wire

// File: src/holdTimer.sv
`default_nettype none

`include "nocArbiter_config.svh"

module holdTimer
  import nocArbiterPkg::*;
(
  input  wire logic       clk,
  input  wire logic       rst,
  input  wire flitId_t    flitId,
  input  wire pktLength_t length,
  input  wire logic       runTimer,
  output logic            timesUp
);

  pktLength_t limit;
  pktLength_t count;
  logic       headerSeen;

  assign headerSeen = (flitId == flitId_t'(`FLIT_HEADER));

  // Limit reloads on any header, whether or not the port holds the grant
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (headerSeen)
      begin
        limit <= length;
      end
      if (runTimer)
      begin
        count <= count + 1'b1;
      end
      else
      begin
        count <= '0;
      end
    end
  end

  assign timesUp = (count == limit);

  // Arbiter must stop the run once the count reaches the limit
  property countWithinLimit;
    @(posedge clk) disable iff (rst)
      (runTimer && (count <= limit) && !headerSeen) |=> (count <= limit);
  endproperty

  assert property (countWithinLimit)
    else $error("holdTimer count ran past its limit");

endmodule

`default_nettype wire

// File: src/nocArbiterPkg.sv
`default_nettype none

`include "nocArbiter_config.svh"

package nocArbiterPkg;

  // Flit-type code checked against the header code
  typedef logic [`FLIT_ID_W-1:0] flitId_t;

  // Hold length in cycles and flit counts
  typedef logic [`PKT_LEN_W-1:0] pktLength_t;

  typedef logic [`FLIT_DATA_W-1:0] flitData_t;

  // Bit 0 is idle and bit p+1 is input port p
  typedef enum logic [`NOC_PORTS:0] {
    GrIdle  = 6'b000001,
    GrLocal = 6'b000010,
    GrNorth = 6'b000100,
    GrEast  = 6'b001000,
    GrWest  = 6'b010000,
    GrSouth = 6'b100000
  } grantState_t;

endpackage

`default_nettype wire

// File: src/nocArbiter_config.svh
`ifndef NOC_ARBITER_CONFIG_SVH
`define NOC_ARBITER_CONFIG_SVH

// Input ports in the order L, N, E, W, S
`define NOC_PORTS 5

`define FLIT_ID_W   3
`define PKT_LEN_W   12
`define FLIT_DATA_W 16

// Flit-type code that carries the packet length
`define FLIT_HEADER 1

`endif

// File: src/portArbiter.sv
`default_nettype none

`include "nocArbiter_config.svh"

module portArbiter
  import nocArbiterPkg::*;
(
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic [`NOC_PORTS-1:0]       req,
  input  wire flitId_t [`NOC_PORTS-1:0]    flitId,
  input  wire pktLength_t [`NOC_PORTS-1:0] length,
  output grantState_t                      grant
);

  grantState_t           nextGrant;
  logic [`NOC_PORTS-1:0] grantPorts;
  logic [`NOC_PORTS-1:0] runTimer;
  logic [`NOC_PORTS-1:0] timesUp;
  logic [`NOC_PORTS-1:0] otherReq;
  int unsigned           curIdx;

  // First requester searching from port start and wrapping
  // around in the order L, N, E, W, S
  function automatic grantState_t pickFrom(
    input logic [`NOC_PORTS-1:0] candidates,
    input int unsigned           start
  );
    logic [`NOC_PORTS:0] oneHot;
    int unsigned         idx;
    logic                found;
    oneHot = '0;
    oneHot[0] = 1'b1;
    found = 1'b0;
    for (int k = 0; k < `NOC_PORTS; k++)
    begin
      idx = (start + k) % `NOC_PORTS;
      if (!found && candidates[idx])
      begin
        oneHot = '0;
        oneHot[idx + 1] = 1'b1;
        found = 1'b1;
      end
    end
    return grantState_t'(oneHot);
  endfunction

  // Per-port view of the grant without the idle bit
  assign grantPorts = grant[`NOC_PORTS:1];

  // Index of the port that holds the grant
  always_comb
  begin
    curIdx = 0;
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      if (grantPorts[p])
      begin
        curIdx = p;
      end
    end
  end

  // Holder keeps running while it requests and has time left
  assign runTimer = grantPorts & req & ~timesUp;

  // Holder is left out of the rotating search
  assign otherReq = req & ~grantPorts;

  always_comb
  begin
    if (|runTimer)
    begin
      nextGrant = grant;
    end
    else if (grant == GrIdle)
    begin
      // Fixed order from idle
      nextGrant = pickFrom(req, 0);
    end
    else
    begin
      nextGrant = pickFrom(otherReq, curIdx + 1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= GrIdle;
    end
    else
    begin
      grant <= nextGrant;
    end
  end

  for (genvar p = 0; p < `NOC_PORTS; p++)
  begin : genTimer
    holdTimer Timer (
      .clk      (clk),
      .rst      (rst),
      .flitId   (flitId[p]),
      .length   (length[p]),
      .runTimer (runTimer[p]),
      .timesUp  (timesUp[p])
    );

    // Grant only moves off a port that let go or ran out of time
    assert property (@(posedge clk) disable iff (rst)
      (grant[p + 1] && req[p] && !timesUp[p]) |=> grant[p + 1])
      else $error("port %0d lost the grant while still holding", p);
  end

  // Exactly one of idle or a port
  assert property (@(posedge clk) disable iff (rst) $onehot(grant))
    else $error("grant is not one-hot: %b", grant);

endmodule

`default_nettype wire

// File: src/switchTraversal.sv
`default_nettype none

`include "nocArbiter_config.svh"

module switchTraversal
  import nocArbiterPkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire grantState_t                grant,
  input  wire logic [`NOC_PORTS-1:0]      req,
  input  wire flitData_t [`NOC_PORTS-1:0] flitData,
  output flitData_t                       outData,
  output logic                            outValid,
  output pktLength_t                      grantFlits
);

  logic [`NOC_PORTS-1:0] grantPorts;
  flitData_t             selData;
  logic                  selValid;
  grantState_t           prevGrant;

  assign grantPorts = grant[`NOC_PORTS:1];

  // Crossbar column for this output
  always_comb
  begin
    selData = '0;
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      if (grantPorts[p])
      begin
        selData = flitData[p];
      end
    end
  end

  // Zero when idle since no port bit is set
  assign selValid = |(grantPorts & req);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outData    <= '0;
      outValid   <= 1'b0;
      prevGrant  <= GrIdle;
      grantFlits <= '0;
    end
    else
    begin
      outData   <= selData;
      outValid  <= selValid;
      prevGrant <= grant;
      // New holder starts its count from zero
      if (grant != prevGrant)
      begin
        grantFlits <= '0;
      end
      else if (outValid)
      begin
        grantFlits <= grantFlits + 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) (grant == GrIdle) |=> !outValid)
    else $error("outValid set after an idle grant");

endmodule

`default_nettype wire

// File: test/arbiterModel.svh
`ifndef ARBITER_MODEL_SVH
`define ARBITER_MODEL_SVH

// A held port runs out once its count reaches the loaded length
function automatic logic timerExpired(
  input pktLength_t count,
  input pktLength_t limit
);
  return count == limit;
endfunction

// Next grant from the current grant, the request levels and the expiry flags
function automatic logic [`NOC_PORTS:0] nextGrantModel(
  input logic [`NOC_PORTS:0]   current,
  input logic [`NOC_PORTS-1:0] reqs,
  input logic [`NOC_PORTS-1:0] expired
);
  logic [`NOC_PORTS:0] result;
  int                  holder;
  int                  port;
  result = '0;
  result[0] = 1'b1;
  holder = -1;
  for (int p = 0; p < `NOC_PORTS; p++)
  begin
    if (current[p + 1])
    begin
      holder = p;
    end
  end
  if (holder < 0)
  begin
    // Scan downwards so the lowest requester is the last one written
    for (int p = `NOC_PORTS - 1; p >= 0; p--)
    begin
      if (reqs[p])
      begin
        result = '0;
        result[p + 1] = 1'b1;
      end
    end
  end
  else if (reqs[holder] && !expired[holder])
  begin
    result = current;
  end
  else
  begin
    // Farthest step first so the nearest port after the holder wins
    for (int step = `NOC_PORTS - 1; step >= 1; step--)
    begin
      port = (holder + step) % `NOC_PORTS;
      if (reqs[port])
      begin
        result = '0;
        result[port + 1] = 1'b1;
      end
    end
  end
  return result;
endfunction

`endif

// File: test/arbiterTb.sv
`default_nettype none

`include "nocArbiter_config.svh"

module arbiterTb
  import nocArbiterPkg::*;
();

  localparam int ClockPeriod    = 8;
  localparam int RandomCycles   = 2000;
  localparam int DirectedCycles = 150;

  logic                        clk = 1'b0;
  logic                        rst;
  logic [`NOC_PORTS-1:0]       req;
  flitId_t [`NOC_PORTS-1:0]    flitId;
  pktLength_t [`NOC_PORTS-1:0] length;
  flitData_t [`NOC_PORTS-1:0]  flitData;
  grantState_t                 grant;
  flitData_t                   outData;
  logic                        outValid;
  pktLength_t                  grantFlits;

  // Reference state advanced on the same edges as the DUT
  logic [`NOC_PORTS:0]         modelGrant;
  logic [`NOC_PORTS:0]         prevModelGrant;
  flitData_t                   modelOutData;
  logic                        modelOutValid;
  pktLength_t                  modelFlits;
  pktLength_t [`NOC_PORTS-1:0] modelLimit;
  pktLength_t [`NOC_PORTS-1:0] modelCount;
  pktLength_t [`NOC_PORTS-1:0] limitNext;
  pktLength_t [`NOC_PORTS-1:0] countNext;
  logic [`NOC_PORTS-1:0]       modelExpired;
  logic [`NOC_PORTS-1:0]       modelRun;
  flitData_t                   selData;
  logic                        selValid;

  int          errorCount = 0;
  logic [31:0] rngState = 32'd91822;
  string       testName = "reset";

  `include "arbiterModel.svh"

  arbiterTop UUT (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .flitId     (flitId),
    .length     (length),
    .flitData   (flitData),
    .grant      (grant),
    .outData    (outData),
    .outValid   (outValid),
    .grantFlits (grantFlits)
  );

  always #(ClockPeriod / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic checkValue(
    input string       name,
    input logic [31:0] expected,
    input logic [31:0] actual
  );
    if (expected !== actual)
    begin
      errorCount++;
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // Headers on the masked ports with one shared length and random data
  task automatic driveCycle(
    input logic [`NOC_PORTS-1:0] reqV,
    input logic [`NOC_PORTS-1:0] headerMask,
    input pktLength_t            lenV
  );
    flitId_t [`NOC_PORTS-1:0]    idV;
    pktLength_t [`NOC_PORTS-1:0] lenAll;
    flitData_t [`NOC_PORTS-1:0]  dataV;
    @(posedge clk);
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      rngState = xorshift32(rngState);
      idV[p] = headerMask[p] ? flitId_t'(`FLIT_HEADER) : '0;
      lenAll[p] = lenV;
      dataV[p] = rngState[15:0];
    end
    req <= reqV;
    flitId <= idV;
    length <= lenAll;
    flitData <= dataV;
  endtask

  task automatic driveRandomCycle();
    flitId_t [`NOC_PORTS-1:0]    idV;
    pktLength_t [`NOC_PORTS-1:0] lenV;
    flitData_t [`NOC_PORTS-1:0]  dataV;
    @(posedge clk);
    rngState = xorshift32(rngState);
    // About three in four ports request in any cycle
    req <= rngState[4:0] | rngState[9:5];
    for (int p = 0; p < `NOC_PORTS; p++)
    begin
      rngState = xorshift32(rngState);
      idV[p] = rngState[2:0];
      lenV[p] = pktLength_t'(rngState[5:3]);
      dataV[p] = rngState[21:6];
    end
    flitId <= idV;
    length <= lenV;
    flitData <= dataV;
  endtask

  always @(posedge clk)
  begin
    if (rst)
    begin
      modelGrant <= GrIdle;
      prevModelGrant <= GrIdle;
      modelOutData <= '0;
      modelOutValid <= 1'b0;
      modelFlits <= '0;
      modelLimit <= '0;
      modelCount <= '0;
    end
    else
    begin
      selData = '0;
      selValid = 1'b0;
      for (int p = 0; p < `NOC_PORTS; p++)
      begin
        modelExpired[p] = timerExpired(modelCount[p], modelLimit[p]);
        modelRun[p] = modelGrant[p + 1] && req[p] && !modelExpired[p];
        limitNext[p] = (flitId[p] == flitId_t'(`FLIT_HEADER)) ? length[p] : modelLimit[p];
        countNext[p] = modelRun[p] ? modelCount[p] + 1'b1 : '0;
        if (modelGrant[p + 1])
        begin
          selData = flitData[p];
          selValid = req[p];
        end
      end
      modelLimit <= limitNext;
      modelCount <= countNext;
      modelGrant <= nextGrantModel(modelGrant, req, modelExpired);
      prevModelGrant <= modelGrant;
      modelOutData <= selData;
      modelOutValid <= selValid;
      if (modelGrant != prevModelGrant)
      begin
        modelFlits <= '0;
      end
      else if (modelOutValid)
      begin
        modelFlits <= modelFlits + 1'b1;
      end
    end
  end

  // Outputs are settled half a cycle after the edge
  always @(negedge clk)
  begin
    if (!rst)
    begin
      checkValue({testName, ".grant"}, 32'(modelGrant), 32'(grant));
      checkValue({testName, ".outValid"}, 32'(modelOutValid), 32'(outValid));
      checkValue({testName, ".outData"}, 32'(modelOutData), 32'(outData));
      checkValue({testName, ".grantFlits"}, 32'(modelFlits), 32'(grantFlits));
    end
  end

  initial
  begin
    #((DirectedCycles + RandomCycles + 100) * ClockPeriod);
    $display("Timeout: the run did not reach its end in the expected time");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    int                  waited;
    int                  holdCycles;
    logic [`NOC_PORTS:0] expGrant;
    rst = 1'b1;
    req = '0;
    flitId = '0;
    length = '0;
    flitData = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    testName = "idleAfterReset";
    repeat (4) driveCycle('0, '0, '0);
    @(negedge clk);
    checkValue("idleAfterReset.grant", 32'(GrIdle), 32'(grant));
    checkValue("idleAfterReset.outValid", 32'(0), 32'(outValid));

    // N, W and S together
    testName = "fixedOrder";
    driveCycle(5'b11010, '0, '0);
    @(posedge clk);
    @(negedge clk);
    checkValue("fixedOrder.first", 32'(GrNorth), 32'(grant));
    repeat (3) driveCycle('0, '0, '0);

    testName = "holdLength";
    driveCycle('0, 5'b00100, pktLength_t'(3));
    driveCycle(5'b00100, '0, '0);
    waited = 0;
    @(negedge clk);
    while (grant != GrEast && waited < 10)
    begin
      @(negedge clk);
      waited++;
    end
    if (waited >= 10)
    begin
      errorCount++;
      $display("East port was never granted while it requested alone");
    end
    holdCycles = 0;
    while (grant == GrEast && holdCycles < 20)
    begin
      holdCycles++;
      @(negedge clk);
    end
    checkValue("holdLength.cycles", 32'(4), 32'(holdCycles));
    checkValue("holdLength.idleGap", 32'(GrIdle), 32'(grant));
    @(negedge clk);
    checkValue("holdLength.regrant", 32'(GrEast), 32'(grant));
    repeat (3) driveCycle('0, '0, '0);

    // Zero length on every port so each holds for one cycle
    testName = "rotation";
    driveCycle('0, 5'b11111, '0);
    driveCycle(5'b11111, '0, '0);
    waited = 0;
    @(negedge clk);
    while (grant == GrIdle && waited < 10)
    begin
      @(negedge clk);
      waited++;
    end
    for (int i = 0; i < 2 * `NOC_PORTS; i++)
    begin
      expGrant = '0;
      expGrant[(i % `NOC_PORTS) + 1] = 1'b1;
      checkValue("rotation.order", 32'(expGrant), 32'(grant));
      @(negedge clk);
    end
    repeat (3) driveCycle('0, '0, '0);

    testName = "random";
    repeat (RandomCycles) driveRandomCycle();
    repeat (3) driveCycle('0, '0, '0);
    @(negedge clk);

    $display("Errors: %0d", errorCount);
    if (errorCount == 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
